// File: hdl/rv_core_defines.svh
// --------------------------------------------------------------------
// RV core definitions
// Widths, reset pc and major opcodes for the RV32I integer pipeline
// --------------------------------------------------------------------

`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

`define RV_XLEN         32              // Data and pc width
`define RV_REG_AW       5               // Register address width

`define RV_PC_RESET     32'h10000000    // First pc after reset

// Major opcodes of the kept instruction groups
`define RV_OPC_OP       7'b0110011      // Register-register ALU
`define RV_OPC_IMM      7'b0010011      // Register-immediate ALU
`define RV_OPC_LUI      7'b0110111
`define RV_OPC_AUIPC    7'b0010111

`endif

// File: hdl/rv_core_pkg.sv
// --------------------------------------------------------------------
// RV core package
// ALU operation encoding and the payloads carried between stages
// --------------------------------------------------------------------

`include "rv_core_defines.svh"

package rv_core_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    typedef logic [31:0] instr_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   pc;
        logic [`RV_REG_AW-1:0] rd;
        alu_op_e               alu_op;
        logic [`RV_XLEN-1:0]   lhs;       // ALU left operand
        logic [`RV_XLEN-1:0]   rhs;       // ALU right operand
        logic                  trap;      // Illegal opcode
    } dec_uop_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   pc;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   value;
        logic                  trap;
    } exe_res_t;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   pc;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   value;     // Zero for traps
        logic                  trap;
    } commit_t;

    // In-flight destination, one per pipe register
    typedef struct packed {
        logic                  valid;
        logic [`RV_REG_AW-1:0] rd;
    } hazard_t;

endpackage

// File: hdl/rv_pipe_reg.sv
// --------------------------------------------------------------------
// RV pipe register
// Single-entry valid/ready stage for any payload with rd and trap,
// reports its held destination for the decode interlock
// --------------------------------------------------------------------

`timescale 1ns/1ps

module rv_pipe_reg #(
    parameter type payload_t = rv_core_pkg::exe_res_t
) (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    input  logic                 in_valid_i,
    output logic                 in_ready_o,
    input  payload_t             in_data_i,
    output logic                 out_valid_o,
    input  logic                 out_ready_i,
    output payload_t             out_data_o,
    output rv_core_pkg::hazard_t pend_o
);

    logic     full_q;                     // Entry held
    payload_t data_q;

    // Free slot, or the held entry leaves this cycle
    assign in_ready_o = !full_q || out_ready_i;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            full_q <= 1'b0;
        end else if (in_ready_o) begin
            full_q <= in_valid_i;         // Refill or drain
        end
    end

    always_ff @(posedge g_clk) begin
        if (in_valid_i && in_ready_o) begin
            data_q <= in_data_i;
        end
    end

    assign out_valid_o = full_q;
    assign out_data_o  = data_q;

    // Traps never write, so they never block a reader
    assign pend_o.valid = full_q && !data_q.trap;
    assign pend_o.rd    = data_q.rd;

endmodule

// File: hdl/rv_decode.sv
// --------------------------------------------------------------------
// RV decode stage
// Tracks the pc, decodes immediates and ALU op, gathers operands and
// interlocks on source registers still in flight
// --------------------------------------------------------------------

`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_decode (
    input  logic                   g_clk,
    input  logic                   g_resetn,
    input  logic                   instr_valid_i,
    input  rv_core_pkg::instr_t    instr_i,
    output logic                   instr_ready_o,
    output logic [`RV_REG_AW-1:0]  rs1_addr_o,
    input  logic [`RV_XLEN-1:0]    rs1_data_i,
    output logic [`RV_REG_AW-1:0]  rs2_addr_o,
    input  logic [`RV_XLEN-1:0]    rs2_data_i,
    input  rv_core_pkg::hazard_t   pend_ex_i,
    input  rv_core_pkg::hazard_t   pend_wb_i,
    output logic                   uop_valid_o,
    output rv_core_pkg::dec_uop_t  uop_o,
    input  logic                   uop_ready_i
);

    import rv_core_pkg::*;

    function automatic logic src_hit(hazard_t pend, logic [`RV_REG_AW-1:0] addr);
        return pend.valid && (pend.rd != '0) && (pend.rd == addr);
    endfunction

    // ----------------------------------------------------------------
    // Instruction fields
    // ----------------------------------------------------------------

    wire [6:0]            opcode   = instr_i[6:0];
    wire [2:0]            funct3   = instr_i[14:12];
    wire [6:0]            funct7   = instr_i[31:25];
    wire [`RV_REG_AW-1:0] rd       = instr_i[11:7];

    wire is_op    = (opcode == `RV_OPC_OP);
    wire is_imm   = (opcode == `RV_OPC_IMM);
    wire is_lui   = (opcode == `RV_OPC_LUI);
    wire is_auipc = (opcode == `RV_OPC_AUIPC);

    wire f7_zero  = (funct7 == 7'b0000000);
    wire f7_alt   = (funct7 == 7'b0100000);   // sub / sra forms
    wire is_shift = (funct3 == 3'b001) || (funct3 == 3'b101);

    logic    legal;
    logic    trap;
    logic    stall;
    logic    accept;
    alu_op_e alu_op;

    logic [`RV_XLEN-1:0] pc_q;

    // ----------------------------------------------------------------
    // Program counter
    // ----------------------------------------------------------------

    assign accept = instr_valid_i && instr_ready_o;

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc_q <= `RV_PC_RESET;
        end else if (accept) begin
            pc_q <= pc_q + `RV_XLEN'd4;      // Traps advance too
        end
    end

    // ----------------------------------------------------------------
    // Immediates and legality
    // ----------------------------------------------------------------

    wire [`RV_XLEN-1:0] imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    wire [`RV_XLEN-1:0] imm_u = {instr_i[31:12], 12'b0};
    wire [`RV_XLEN-1:0] shamt = {27'b0, instr_i[24:20]};

    always_comb begin
        legal = is_lui || is_auipc;
        if (is_op) begin
            legal = f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
        end else if (is_imm) begin
            case (funct3)
                3'b001:  legal = f7_zero;             // slli
                3'b101:  legal = f7_zero || f7_alt;   // srli, srai
                default: legal = 1'b1;
            endcase
        end
    end

    assign trap = !legal;

    // ----------------------------------------------------------------
    // ALU operation
    // ----------------------------------------------------------------

    always_comb begin
        case (funct3)
            3'b000:  alu_op = (is_op && funct7[5]) ? ALU_SUB : ALU_ADD;
            3'b001:  alu_op = ALU_SLL;
            3'b010:  alu_op = ALU_SLT;
            3'b011:  alu_op = ALU_SLTU;
            3'b100:  alu_op = ALU_XOR;
            3'b101:  alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
            3'b110:  alu_op = ALU_OR;
            default: alu_op = ALU_AND;
        endcase
        if (is_lui || is_auipc) begin
            alu_op = ALU_ADD;                 // lhs + upper immediate
        end
    end

    // ----------------------------------------------------------------
    // Operands and interlock
    // ----------------------------------------------------------------

    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];

    // Only sources the instruction reads can stall it
    assign stall = ((is_op || is_imm) &&
                    (src_hit(pend_ex_i, rs1_addr_o) || src_hit(pend_wb_i, rs1_addr_o))) ||
                   (is_op &&
                    (src_hit(pend_ex_i, rs2_addr_o) || src_hit(pend_wb_i, rs2_addr_o)));

    assign instr_ready_o = g_resetn && uop_ready_i && !stall;
    assign uop_valid_o   = instr_valid_i && !stall;

    always_comb begin
        uop_o.pc     = pc_q;
        uop_o.rd     = trap ? '0 : rd;
        uop_o.alu_op = alu_op;
        uop_o.trap   = trap;
        uop_o.lhs    = is_auipc ? pc_q :
                       is_lui   ? '0   :
                                  rs1_data_i;
        uop_o.rhs    = is_op                ? rs2_data_i :
                       (is_imm && is_shift) ? shamt      :
                       is_imm               ? imm_i      :
                                              imm_u;
    end

endmodule

// File: hdl/rv_execute.sv
// --------------------------------------------------------------------
// RV execute stage
// Combinational ALU producing the value to commit
// --------------------------------------------------------------------

`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_execute (
    input  logic                  uop_valid_i,
    input  rv_core_pkg::dec_uop_t uop_i,
    output logic                  uop_ready_o,
    output logic                  res_valid_o,
    output rv_core_pkg::exe_res_t res_o,
    input  logic                  res_ready_i
);

    import rv_core_pkg::*;

    logic [`RV_XLEN-1:0] lhs;
    logic [`RV_XLEN-1:0] rhs;
    logic [4:0]          sh;
    logic [`RV_XLEN-1:0] value;

    assign lhs = uop_i.lhs;
    assign rhs = uop_i.rhs;
    assign sh  = rhs[4:0];                        // Shift amount

    // ----------------------------------------------------------------
    // ALU
    // ----------------------------------------------------------------

    always_comb begin
        case (uop_i.alu_op)
            ALU_ADD:  value = lhs + rhs;
            ALU_SUB:  value = lhs - rhs;
            ALU_AND:  value = lhs & rhs;
            ALU_OR:   value = lhs | rhs;
            ALU_XOR:  value = lhs ^ rhs;
            ALU_SLL:  value = lhs << sh;
            ALU_SRL:  value = lhs >> sh;
            ALU_SRA:  value = $signed(lhs) >>> sh;
            ALU_SLT:  value = {{(`RV_XLEN-1){1'b0}}, $signed(lhs) < $signed(rhs)};
            ALU_SLTU: value = {{(`RV_XLEN-1){1'b0}}, lhs < rhs};
            default:  value = '0;                 // Unused encodings
        endcase
    end

    always_comb begin
        res_o.pc    = uop_i.pc;
        res_o.rd    = uop_i.rd;
        res_o.value = value;
        res_o.trap  = uop_i.trap;
    end

    // No state here, handshake passes straight through
    assign res_valid_o = uop_valid_i;
    assign uop_ready_o = res_ready_i;

endmodule

// File: hdl/rv_result.sv
// --------------------------------------------------------------------
// RV result stage
// Register file with two read ports, commits on the output handshake
// --------------------------------------------------------------------

`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_result (
    input  logic                  g_clk,
    input  logic                  g_resetn,
    input  logic                  res_valid_i,
    input  rv_core_pkg::exe_res_t res_i,
    output logic                  res_ready_o,
    input  logic [`RV_REG_AW-1:0] rs1_addr_i,
    output logic [`RV_XLEN-1:0]   rs1_data_o,
    input  logic [`RV_REG_AW-1:0] rs2_addr_i,
    output logic [`RV_XLEN-1:0]   rs2_data_o,
    output logic                  commit_valid_o,
    output rv_core_pkg::commit_t  commit_o,
    input  logic                  commit_ready_i
);

    logic [`RV_XLEN-1:0] regs [1:31];             // x0 is not stored
    logic                wr_en;

    assign wr_en = g_resetn && res_valid_i && commit_ready_i &&
                   !res_i.trap && (res_i.rd != '0);

    always_ff @(posedge g_clk) begin
        if (wr_en) begin
            regs[res_i.rd] <= res_i.value;
        end
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

    // ----------------------------------------------------------------
    // Committed record
    // ----------------------------------------------------------------

    assign commit_valid_o = res_valid_i;
    assign res_ready_o    = commit_ready_i;

    always_comb begin
        commit_o.pc    = res_i.pc;
        commit_o.rd    = res_i.rd;
        commit_o.value = res_i.trap ? '0 : res_i.value;
        commit_o.trap  = res_i.trap;
    end

endmodule

// File: hdl/rv_core_top.sv
// --------------------------------------------------------------------
// RV core top
// Decode, execute and result stages joined by two pipe registers
// --------------------------------------------------------------------

`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_core_top (
    input  logic                 g_clk,
    input  logic                 g_resetn,
    input  logic                 instr_valid_i,
    input  rv_core_pkg::instr_t  instr_i,
    output logic                 instr_ready_o,
    output logic                 res_valid_o,
    output rv_core_pkg::commit_t res_o,
    input  logic                 res_ready_i
);

    import rv_core_pkg::*;

    logic [`RV_REG_AW-1:0] rs1_addr;
    logic [`RV_REG_AW-1:0] rs2_addr;
    logic [`RV_XLEN-1:0]   rs1_data;
    logic [`RV_XLEN-1:0]   rs2_data;

    hazard_t  pend_ex;
    hazard_t  pend_wb;

    logic     dec_valid;                          // Decode to u_dx_reg
    logic     dec_ready;
    dec_uop_t dec_uop;
    logic     ex_valid;                           // u_dx_reg to execute
    logic     ex_ready;
    dec_uop_t ex_uop;
    logic     exr_valid;                          // Execute to u_xr_reg
    logic     exr_ready;
    exe_res_t exr_res;
    logic     wb_valid;                           // u_xr_reg to result
    logic     wb_ready;
    exe_res_t wb_res;

    rv_decode u_decode (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .instr_ready_o (instr_ready_o),
        .rs1_addr_o    (rs1_addr),
        .rs1_data_i    (rs1_data),
        .rs2_addr_o    (rs2_addr),
        .rs2_data_i    (rs2_data),
        .pend_ex_i     (pend_ex),
        .pend_wb_i     (pend_wb),
        .uop_valid_o   (dec_valid),
        .uop_o         (dec_uop),
        .uop_ready_i   (dec_ready)
    );

    rv_pipe_reg #(.payload_t(dec_uop_t)) u_dx_reg (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .in_valid_i  (dec_valid),
        .in_ready_o  (dec_ready),
        .in_data_i   (dec_uop),
        .out_valid_o (ex_valid),
        .out_ready_i (ex_ready),
        .out_data_o  (ex_uop),
        .pend_o      (pend_ex)
    );

    rv_execute u_execute (
        .uop_valid_i (ex_valid),
        .uop_i       (ex_uop),
        .uop_ready_o (ex_ready),
        .res_valid_o (exr_valid),
        .res_o       (exr_res),
        .res_ready_i (exr_ready)
    );

    rv_pipe_reg #(.payload_t(exe_res_t)) u_xr_reg (
        .g_clk       (g_clk),
        .g_resetn    (g_resetn),
        .in_valid_i  (exr_valid),
        .in_ready_o  (exr_ready),
        .in_data_i   (exr_res),
        .out_valid_o (wb_valid),
        .out_ready_i (wb_ready),
        .out_data_o  (wb_res),
        .pend_o      (pend_wb)
    );

    rv_result u_result (
        .g_clk          (g_clk),
        .g_resetn       (g_resetn),
        .res_valid_i    (wb_valid),
        .res_i          (wb_res),
        .res_ready_o    (wb_ready),
        .rs1_addr_i     (rs1_addr),
        .rs1_data_o     (rs1_data),
        .rs2_addr_i     (rs2_addr),
        .rs2_data_o     (rs2_data),
        .commit_valid_o (res_valid_o),
        .commit_o       (res_o),
        .commit_ready_i (res_ready_i)
    );

endmodule

// File: dv/rv_core_chk.sv
// --------------------------------------------------------------------
// RV core handshake checker
// Output hold under back-pressure and port state during reset
// --------------------------------------------------------------------

`timescale 1ns/1ps

module rv_core_chk (
    input logic                 g_clk,
    input logic                 g_resetn,
    input logic                 instr_ready_o,
    input logic                 res_valid_o,
    input rv_core_pkg::commit_t res_o,
    input logic                 res_ready_i
);

    int n_fail = 0;                               // Failed assertions so far

    // Record stays put until taken
    a_res_hold: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (res_valid_o && !res_ready_i) |=> (res_valid_o && $stable(res_o)))
        else begin
            $error("res_o changed or res_valid_o dropped before acceptance");
            n_fail++;
        end

    // Flops settle on the first reset edge
    a_res_reset: assert property (@(posedge g_clk)
        !g_resetn |=> !res_valid_o)
        else begin
            $error("res_valid_o high after a reset cycle");
            n_fail++;
        end

    a_instr_reset: assert property (@(posedge g_clk)
        !g_resetn |-> !instr_ready_o)
        else begin
            $error("instr_ready_o high during reset");
            n_fail++;
        end

endmodule

bind rv_core_top rv_core_chk u_chk (
    .g_clk         (g_clk),
    .g_resetn      (g_resetn),
    .instr_ready_o (instr_ready_o),
    .res_valid_o   (res_valid_o),
    .res_o         (res_o),
    .res_ready_i   (res_ready_i)
);

// File: dv/rv_core_tb.sv
// --------------------------------------------------------------------
// RV core testbench
// Random RV32I programs run against an ISA model, every committed
// record compared in order
// --------------------------------------------------------------------

`timescale 1ns/1ps
`include "rv_core_defines.svh"

module rv_core_tb;

    import rv_core_pkg::*;

    localparam int WAIT_LIMIT = 200;              // Cycles per wait

    logic    g_clk;
    logic    g_resetn;
    logic    instr_valid_i;
    instr_t  instr_i;
    logic    instr_ready_o;
    logic    res_valid_o;
    commit_t res_o;
    logic    res_ready_i;

    logic [31:0] model_regs [0:31];
    logic [31:0] model_pc;
    commit_t     exp_q [$];                       // Predicted records in order
    logic        random_ready;
    logic        hung;
    int          n_errors;
    int          n_checked;
    int          n_issued;

    rv_core_top dut0 (
        .g_clk         (g_clk),
        .g_resetn      (g_resetn),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .instr_ready_o (instr_ready_o),
        .res_valid_o   (res_valid_o),
        .res_o         (res_o),
        .res_ready_i   (res_ready_i)
    );

    initial begin
        g_clk = 1'b0;
        forever #50 g_clk = ~g_clk;
    end

    // ----------------------------------------------------------------
    // ISA reference model
    // ----------------------------------------------------------------

    task automatic model_issue(input instr_t w);
        commit_t     c;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic        ok;
        a       = model_regs[w[19:15]];
        b       = model_regs[w[24:20]];
        imm     = {{20{w[31]}}, w[31:20]};
        ok      = 1'b1;
        c.value = '0;
        case (w[6:0])
            `RV_OPC_OP: begin
                case ({w[31:25], w[14:12]})
                    {7'h00, 3'd0}: c.value = a + b;
                    {7'h20, 3'd0}: c.value = a - b;
                    {7'h00, 3'd1}: c.value = a << b[4:0];
                    {7'h00, 3'd2}: c.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    {7'h00, 3'd3}: c.value = (a < b) ? 32'd1 : 32'd0;
                    {7'h00, 3'd4}: c.value = a ^ b;
                    {7'h00, 3'd5}: c.value = a >> b[4:0];
                    {7'h20, 3'd5}: c.value = $signed(a) >>> b[4:0];
                    {7'h00, 3'd6}: c.value = a | b;
                    {7'h00, 3'd7}: c.value = a & b;
                    default:       ok = 1'b0;
                endcase
            end
            `RV_OPC_IMM: begin
                case (w[14:12])
                    3'd0: c.value = a + imm;
                    3'd2: c.value = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
                    3'd3: c.value = (a < imm) ? 32'd1 : 32'd0;   // Unsigned vs sign-extended
                    3'd4: c.value = a ^ imm;
                    3'd6: c.value = a | imm;
                    3'd7: c.value = a & imm;
                    3'd1: begin
                        ok      = (w[31:25] == 7'h00);
                        c.value = a << w[24:20];
                    end
                    default: begin
                        ok = (w[31:25] == 7'h00) || (w[31:25] == 7'h20);
                        if (w[30]) begin
                            c.value = $signed(a) >>> w[24:20];
                        end else begin
                            c.value = a >> w[24:20];
                        end
                    end
                endcase
            end
            `RV_OPC_LUI:   c.value = {w[31:12], 12'h000};
            `RV_OPC_AUIPC: c.value = model_pc + {w[31:12], 12'h000};
            default:       ok = 1'b0;
        endcase
        c.pc   = model_pc;
        c.trap = !ok;
        c.rd   = ok ? w[11:7] : 5'd0;           // Traps carry no destination
        if (!ok) begin
            c.value = '0;
        end else if (w[11:7] != 5'd0) begin
            model_regs[w[11:7]] = c.value;
        end
        model_pc = model_pc + 32'd4;
        n_issued++;
        exp_q.push_back(c);
    endtask

    // ----------------------------------------------------------------
    // Output monitor
    // ----------------------------------------------------------------

    initial begin
        commit_t e;
        forever begin
            @(posedge g_clk);
            if (g_resetn && res_valid_o && res_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("Unexpected record at pc %h with nothing outstanding", res_o.pc);
                    n_errors++;
                end else begin
                    e = exp_q.pop_front();
                    n_checked++;
                    if (res_o.pc !== e.pc) begin
                        $display("FAILED res_o.pc: expected %h, got %h", e.pc, res_o.pc);
                        n_errors++;
                    end
                    if (res_o.rd !== e.rd) begin
                        $display("FAILED res_o.rd: expected %h, got %h", e.rd, res_o.rd);
                        n_errors++;
                    end
                    if (res_o.value !== e.value) begin
                        $display("FAILED res_o.value: expected %h, got %h", e.value, res_o.value);
                        n_errors++;
                    end
                    if (res_o.trap !== e.trap) begin
                        $display("FAILED res_o.trap: expected %h, got %h", e.trap, res_o.trap);
                        n_errors++;
                    end
                end
            end
        end
    end

    // ----------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------

    task automatic next_fall();
        @(negedge g_clk);
        res_ready_i = random_ready ? ($urandom_range(3) != 0) : 1'b1;
    endtask

    task automatic drive_instr(input instr_t w);
        int waited;
        if (hung) begin
            return;
        end
        waited        = 0;
        instr_valid_i = 1'b1;
        instr_i       = w;
        @(posedge g_clk);
        while (!instr_ready_o && waited < WAIT_LIMIT) begin
            waited++;
            next_fall();
            @(posedge g_clk);
        end
        if (instr_ready_o) begin
            model_issue(w);
        end else begin
            $display("Timeout: instruction %h was never accepted", w);
            hung = 1'b1;
        end
        next_fall();
        instr_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
            waited++;
            next_fall();
        end
        if (exp_q.size() != 0 && !hung) begin
            $display("Timeout: %0d records never came out", exp_q.size());
            hung = 1'b1;
        end
        repeat (3) next_fall();                   // Room for a stray duplicate
    endtask

    function automatic instr_t enc_r(input int kind, input logic [4:0] rd,
                                     input logic [4:0] rs1, input logic [4:0] rs2);
        logic [2:0] f3;
        logic [6:0] f7;
        f7 = (kind == 1 || kind == 7) ? 7'h20 : 7'h00;   // sub, sra
        case (kind)
            0, 1:    f3 = 3'd0;
            2:       f3 = 3'd1;
            3:       f3 = 3'd2;
            4:       f3 = 3'd3;
            5:       f3 = 3'd4;
            6, 7:    f3 = 3'd5;
            8:       f3 = 3'd6;
            default: f3 = 3'd7;
        endcase
        return {f7, rs2, rs1, f3, rd, `RV_OPC_OP};
    endfunction

    function automatic instr_t enc_i(input int kind, input logic [4:0] rd,
                                     input logic [4:0] rs1, input logic [11:0] imm);
        logic [2:0]  f3;
        logic [11:0] field;
        field = imm;
        case (kind)
            0:       f3 = 3'd0;
            1:       f3 = 3'd2;
            2:       f3 = 3'd3;
            3:       f3 = 3'd4;
            4:       f3 = 3'd6;
            5:       f3 = 3'd7;
            6:       f3 = 3'd1;
            default: f3 = 3'd5;
        endcase
        if (kind >= 6) begin
            field[11:5] = (kind == 8) ? 7'h20 : 7'h00;   // Shift kinds
        end
        return {field, rs1, f3, rd, `RV_OPC_IMM};
    endfunction

    function automatic instr_t enc_u(input logic auipc, input logic [4:0] rd,
                                     input logic [19:0] imm);
        return {imm, rd, auipc ? `RV_OPC_AUIPC : `RV_OPC_LUI};
    endfunction

    function automatic instr_t rand_legal(input int maxr);
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        rd  = 5'($urandom_range(maxr, 1));
        rs1 = 5'($urandom_range(maxr, 0));
        rs2 = 5'($urandom_range(maxr, 0));
        case ($urandom_range(4))
            0, 1:    return enc_r($urandom_range(9), rd, rs1, rs2);
            2, 3:    return enc_i($urandom_range(8), rd, rs1, 12'($urandom()));
            default: return enc_u($urandom_range(1) == 1, rd, 20'($urandom()));
        endcase
    endfunction

    function automatic instr_t rand_illegal();
        instr_t w;
        w = $urandom();
        case ($urandom_range(2))
            0: begin
                w[6:0]   = `RV_OPC_OP;
                w[31:25] = 7'h01;                 // Multiply group
            end
            1: begin
                w[6:0]   = `RV_OPC_IMM;
                w[14:12] = 3'd1;
                w[31:25] = 7'h10;                 // slli with bad upper bits
            end
            default: begin
                while (w[6:0] == `RV_OPC_OP || w[6:0] == `RV_OPC_IMM ||
                       w[6:0] == `RV_OPC_LUI || w[6:0] == `RV_OPC_AUIPC) begin
                    w[6:0] = 7'($urandom());
                end
            end
        endcase
        return w;
    endfunction

    task automatic report_test(input string name, input int errs0, input int issued0);
        $display("%-8s %0d instructions, %0d errors", name, n_issued - issued0,
                 n_errors - errs0);
    endtask

    // ----------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------

    initial begin
        int e0;
        int i0;
        void'($urandom(32'hd2e1));
        g_resetn      = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        res_ready_i   = 1'b0;
        random_ready  = 1'b0;
        hung          = 1'b0;
        n_errors      = 0;
        n_checked     = 0;
        n_issued      = 0;
        model_pc      = `RV_PC_RESET;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        repeat (5) @(negedge g_clk);
        g_resetn    = 1'b1;
        res_ready_i = 1'b1;

        // Register-register ops, after loading x1..x7
        e0 = n_errors;
        i0 = n_issued;
        for (int r = 1; r < 8; r++) begin
            drive_instr(enc_u(1'b0, 5'(r), 20'($urandom())));
            drive_instr(enc_i(0, 5'(r), 5'(r), 12'($urandom())));
        end
        for (int i = 0; i < 40; i++) begin
            drive_instr(enc_r(i % 10, 5'($urandom_range(7, 1)),
                              5'($urandom_range(7)), 5'($urandom_range(7))));
        end
        wait_drain();
        report_test("reg_ops", e0, i0);

        e0 = n_errors;
        i0 = n_issued;
        for (int i = 0; i < 45; i++) begin
            drive_instr(enc_i(i % 9, 5'($urandom_range(7, 1)),
                              5'($urandom_range(7)), 12'($urandom())));
        end
        wait_drain();
        report_test("imm_ops", e0, i0);

        e0 = n_errors;
        i0 = n_issued;
        for (int i = 0; i < 20; i++) begin
            drive_instr(enc_u(i % 2 == 1, 5'($urandom_range(7, 1)), 20'($urandom())));
        end
        wait_drain();
        report_test("upper", e0, i0);

        // Dense dependencies on x1..x3 under back-pressure
        e0 = n_errors;
        i0 = n_issued;
        random_ready = 1'b1;
        for (int i = 0; i < 80; i++) begin
            if ($urandom_range(3) == 0) begin
                next_fall();                      // Idle gap
            end
            drive_instr(rand_legal(3));
        end
        wait_drain();
        report_test("chains", e0, i0);

        e0 = n_errors;
        i0 = n_issued;
        for (int i = 0; i < 30; i++) begin
            drive_instr(($urandom_range(2) == 0) ? rand_legal(7) : rand_illegal());
        end
        for (int r = 1; r < 8; r++) begin
            drive_instr(enc_r(8, 5'd0, 5'(r), 5'd0));   // Read back through rd x0
        end
        wait_drain();
        report_test("illegal", e0, i0);

        e0 = n_errors;
        i0 = n_issued;
        random_ready = 1'b0;
        for (int i = 0; i < 20; i++) begin
            instr_i = rand_legal(7);
            instr_i[11:7] = 5'd0;
            drive_instr(instr_i);
        end
        for (int i = 0; i < 8; i++) begin
            drive_instr(enc_r($urandom_range(9), 5'($urandom_range(7, 1)), 5'd0, 5'd0));
        end
        wait_drain();
        report_test("x0", e0, i0);

        $display("Summary: %0d instructions, %0d records checked, %0d errors",
                 n_issued, n_checked, n_errors);
        if (n_errors == 0 && !hung && dut0.u_chk.n_fail == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+hdl
hdl/rv_core_pkg.sv
hdl/rv_pipe_reg.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_result.sv
hdl/rv_core_top.sv
dv/rv_core_chk.sv
dv/rv_core_tb.sv
